/* tb.f */
gb_io_pkg.sv
joypad.sv
serial_port.sv
irq_ctrl.sv
gb_io.sv
tb_gb_io.sv

/* run.sh */
#!/bin/sh
# build the gb_io testbench with Verilator and run it
verilator --binary --timing --assert --top-module tb_gb_io -f tb.f -o tb_gb_io \
	&& ./obj_dir/tb_gb_io \
	|| exit 1

/* tb_gb_io.sv */
/*
 * directed testbench for the io register and interrupt block
 *   clock, reset, bus tasks, value check, cycle limit
 *   reset/open bus, joypad, serial, priority and external source tests
 */
`timescale 1ns/1ps
`default_nettype none

module tb_gb_io;
	import gb_io_pkg::*;

	localparam int SERIAL_EDGES = SERIAL_BITS * SERIAL_BIT_CYCLES; // 4096 edges per transfer
	// one transfer plus the 5000 cycle idle check, about 9400 cycles in all
	localparam int TIMEOUT_CYCLES = 10000;

	logic       clk;
	logic       reset;
	cpu_bus_t   bus;
	logic [7:0] buttons;
	ext_irq_t   ext;
	byte_t      rdata;
	logic       irq_n;

	logic       last_irq_n;          // irq_n seen with the last read
	logic [31:0] rng_state;
	int         cycle_count = 0;

	gb_io dut0 (
		.clk     (clk),
		.reset   (reset),
		.bus     (bus),
		.buttons (buttons),
		.ext     (ext),
		.rdata   (rdata),
		.irq_n   (irq_n)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	// hard limit on run length
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: tests still running after %0d clock cycles", cycle_count);
			$display("Result: FAILED");
			$fatal(1, "simulation timed out");
		end
	end

	// ----------------------------------------------------------------------
	// helpers
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic byte_t rand_byte();
		rng_state = xorshift32(rng_state);
		return rng_state[7:0];
	endfunction

	task automatic check(input byte_t got, input byte_t expected, input string message);
		if (got !== expected) begin
			$display("ERROR at %0t ns: %s, got %02h, expected %02h",
				$time, message, got, expected);
			$display("Result: FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// leaves the caller 5 ns after a rising edge
	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#5;
		end
	endtask

	task automatic bus_write(input addr_t addr, input byte_t data);
		bus.addr  = addr;
		bus.wdata = data;
		bus.wr    = 1'b1;
		wait_cycles(1); // this edge takes the write
		bus.wr    = 1'b0;
	endtask

	// one cycle, sees the state after the previous edge
	task automatic bus_read(input addr_t addr, output byte_t data);
		bus.addr = addr;
		bus.wr   = 1'b0;
		#10;
		data       = rdata;
		last_irq_n = irq_n;
		wait_cycles(1);
	endtask

	task automatic expect_read(input addr_t addr, input byte_t expected, input string message);
		byte_t got;
		bus_read(addr, got);
		check(got, expected, message);
	endtask

	// ack high for one cycle, low edge after it clears a flag
	task automatic ack_read(output byte_t vec);
		bus.ack = 1'b1;
		#10;
		vec = rdata;
		wait_cycles(1);
		bus.ack = 1'b0;
		wait_cycles(1);
	endtask

	function automatic logic owned(input addr_t a);
		return a == ADDR_JOYP || a == ADDR_SB || a == ADDR_SC || a == ADDR_IF || a == ADDR_IE;
	endfunction

	// P1 read model, a line is low when a selected group has its key down
	function automatic byte_t joyp_expected(input logic [7:0] pressed, input logic [1:0] sel);
		byte_t r;
		r = {2'b11, sel, 4'b1111};
		for (int j = 0; j < 4; j++) begin
			if (!sel[0] && pressed[j]) begin
				r[j] = 1'b0; // direction key
			end
			if (!sel[1] && pressed[j + 4]) begin
				r[j] = 1'b0; // action key
			end
		end
		return r;
	endfunction

	function automatic byte_t vector_for(input logic [4:0] flags);
		if (flags[0]) return 8'h40; // vblank
		if (flags[1]) return 8'h48; // lcd stat
		if (flags[2]) return 8'h50; // timer
		if (flags[3]) return 8'h58; // serial
		if (flags[4]) return 8'h60; // joypad
		return 8'h55;
	endfunction

	// ----------------------------------------------------------------------
	// tests
	task automatic test_reset_state();
		addr_t a;
		expect_read(ADDR_IE, 8'h00, "IE after reset"); // no fixed upper bits
		expect_read(ADDR_IF, 8'he0, "IF after reset");
		check(8'(last_irq_n), 8'h01, "irq_n after reset");
		expect_read(ADDR_SC, 8'h7e, "SC after reset");
		expect_read(ADDR_SB, 8'hff, "SB read");
		expect_read(ADDR_JOYP, 8'hcf, "JOYP after reset");
		for (int i = 0; i < 6; i++) begin
			a = {rand_byte(), rand_byte()};
			if (owned(a)) begin
				a = a ^ 16'h8000; // move it off the io page
			end
			expect_read(a, 8'hff, "unowned address");
		end
		bus_write(ADDR_SB, rand_byte()); // dropped
		expect_read(ADDR_SB, 8'hff, "SB after write");
	endtask

	task automatic test_joypad();
		logic [7:0] pattern;
		logic [1:0] sel;
		logic [1:0] pick;
		for (int i = 0; i < 8; i++) begin
			pattern = rand_byte();
			buttons = pattern;
			for (int s = 0; s < 4; s++) begin
				sel = 2'(s);
				bus_write(ADDR_JOYP, {2'b00, sel, 4'h0});
				expect_read(ADDR_JOYP, joyp_expected(pattern, sel), "joypad read");
			end
		end
		// key press interrupt, directions selected
		buttons = 8'h00;
		bus_write(ADDR_JOYP, 8'h20);
		wait_cycles(4); // synchronizer settles
		bus_write(ADDR_IF, 8'h00);
		pick    = 2'(rand_byte());
		buttons = 8'h01 << pick;
		wait_cycles(2);
		expect_read(ADDR_IF, 8'he0, "IF4 two edges after press");
		expect_read(ADDR_IF, 8'hf0, "IF4 three edges after press");
		buttons = 8'h00; // release, rising lines set nothing
		wait_cycles(4);
		expect_read(ADDR_IF, 8'hf0, "IF after release");
		bus_write(ADDR_IF, 8'h00);
	endtask

	task automatic test_serial();
		bus_write(ADDR_IE, 8'h00);
		bus_write(ADDR_IF, 8'h00);
		bus_write(ADDR_SC, 8'h81); // start, internal clock
		expect_read(ADDR_SC, 8'hff, "SC during transfer");
		wait_cycles(SERIAL_EDGES - 3);
		expect_read(ADDR_IF, 8'he0, "IF before transfer end");
		expect_read(ADDR_SC, 8'hff, "SC one edge before end");
		expect_read(ADDR_SC, 8'h7f, "SC at transfer end");
		expect_read(ADDR_IF, 8'he8, "serial flag after transfer");
		// external clock, nobody clocks the port
		bus_write(ADDR_IF, 8'h00);
		bus_write(ADDR_SC, 8'h80);
		expect_read(ADDR_SC, 8'hfe, "SC external clock");
		wait_cycles(5000);
		expect_read(ADDR_IF, 8'he0, "IF with external clock");
		expect_read(ADDR_SC, 8'hfe, "SC still busy");
	endtask

	task automatic test_priority();
		byte_t      data;
		byte_t      vec;
		logic [4:0] flags;
		bus_write(ADDR_IE, 8'h1f);
		for (int i = 0; i < 24; i++) begin
			data = (i == 0) ? 8'h00 : rand_byte(); // first pass nothing pending
			flags = data[4:0];
			bus_write(ADDR_IF, data);
			expect_read(ADDR_IF, {3'b111, flags}, "IF after write");
			check(8'(last_irq_n), (flags == 5'd0) ? 8'h01 : 8'h00, "irq_n with IE 1F");
			ack_read(vec);
			check(vec, vector_for(flags), "ack vector");
			expect_read(ADDR_IF, {3'b111, flags & (flags - 5'd1)}, "IF after ack");
		end
		bus_write(ADDR_IF, 8'h00);
	endtask

	task automatic test_external();
		bus_write(ADDR_IE, 8'h00);
		bus_write(ADDR_IF, 8'h00);
		ext.timer = 1'b1; // timer pulse
		wait_cycles(1);
		ext.timer = 1'b0;
		expect_read(ADDR_IF, 8'he4, "timer flag");
		check(8'(last_irq_n), 8'h01, "irq_n timer masked");
		bus_write(ADDR_IE, 8'h04);
		expect_read(ADDR_IF, 8'he4, "timer flag kept");
		check(8'(last_irq_n), 8'h00, "irq_n timer enabled");
		bus_write(ADDR_IF, 8'h00);
		ext.lcd = 1'b1; // lcd pulse
		wait_cycles(1);
		ext.lcd = 1'b0;
		expect_read(ADDR_IF, 8'he2, "lcd flag");
		check(8'(last_irq_n), 8'h01, "irq_n lcd masked");
		bus_write(ADDR_IE, 8'h02);
		expect_read(ADDR_IE, 8'h02, "IE readback");
		check(8'(last_irq_n), 8'h00, "irq_n lcd enabled");
		bus_write(ADDR_IF, 8'h00);
		ext.vblank = 1'b1; // vblank level rises
		wait_cycles(2);
		expect_read(ADDR_IF, 8'he0, "vblank two edges after rise");
		expect_read(ADDR_IF, 8'he1, "vblank three edges after rise");
		check(8'(last_irq_n), 8'h01, "irq_n vblank masked");
		bus_write(ADDR_IE, 8'h01);
		expect_read(ADDR_IF, 8'he1, "vblank flag kept");
		check(8'(last_irq_n), 8'h00, "irq_n vblank enabled");
		ext.timer = 1'b1;
		wait_cycles(1);
		ext.timer = 1'b0;
		expect_read(ADDR_IF, 8'he5, "vblank and timer flags");
		bus_write(ADDR_IF, 8'h00); // clears everything
		expect_read(ADDR_IF, 8'he0, "IF cleared");
		check(8'(last_irq_n), 8'h01, "irq_n after clear");
		ext.vblank = 1'b0;
	endtask

	// ----------------------------------------------------------------------
	// main sequence
	initial begin
		reset      = 1'b1;
		bus        = '0;
		buttons    = 8'h00;
		ext        = '0;
		last_irq_n = 1'b1;
		rng_state  = 32'd7940;
		repeat (2) @(posedge clk); // two reset edges
		#5;
		reset = 1'b0;
		test_reset_state();
		test_joypad();
		test_serial();
		test_priority();
		test_external();
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* gb_io.sv */
/*
 * io register and interrupt subsystem, top level
 *   address decode and write strobes
 *   joypad, serial port and interrupt controller instances
 *   cpu read multiplexer
 */
`timescale 1ns/1ps
`default_nettype none

module gb_io (
	input  wire                      clk,
	input  wire                      reset,
	input  wire gb_io_pkg::cpu_bus_t bus,
	input  wire [7:0]                buttons,
	input  wire gb_io_pkg::ext_irq_t ext,
	output gb_io_pkg::byte_t         rdata,
	output logic                     irq_n
);
	import gb_io_pkg::*;

	logic       hit_joyp, hit_sb, hit_sc, hit_if, hit_ie;
	io_sel_t    wsel;
	byte_t      joy_rdata;
	byte_t      sc_rdata;
	byte_t      if_rdata;
	byte_t      ie_rdata;
	byte_t      vector;
	joy_lines_t lines;
	logic       serial_irq;

	// ----------------------------------------------------------------------
	// address decode
	assign hit_joyp = (bus.addr == ADDR_JOYP);
	assign hit_sb   = (bus.addr == ADDR_SB);
	assign hit_sc   = (bus.addr == ADDR_SC);
	assign hit_if   = (bus.addr == ADDR_IF);
	assign hit_ie   = (bus.addr == ADDR_IE);

	assign wsel.joyp   = hit_joyp & bus.wr;
	assign wsel.sc     = hit_sc & bus.wr;
	assign wsel.if_reg = hit_if & bus.wr;
	assign wsel.ie     = hit_ie & bus.wr;

	// ----------------------------------------------------------------------
	// blocks
	joypad joy0 (
		.clk     (clk),
		.reset   (reset),
		.sel_wr  (wsel.joyp),
		.wdata   (bus.wdata),
		.buttons (buttons),
		.rdata   (joy_rdata),
		.lines   (lines)
	);

	serial_port ser0 (
		.clk        (clk),
		.reset      (reset),
		.sel_wr     (wsel.sc),
		.wdata      (bus.wdata),
		.rdata      (sc_rdata),
		.serial_irq (serial_irq)
	);

	irq_ctrl irq0 (
		.clk        (clk),
		.reset      (reset),
		.if_wr      (wsel.if_reg),
		.ie_wr      (wsel.ie),
		.wdata      (bus.wdata),
		.ack        (bus.ack),
		.ext        (ext),
		.lines      (lines),
		.serial_irq (serial_irq),
		.if_rdata   (if_rdata),
		.ie_rdata   (ie_rdata),
		.vector     (vector),
		.irq_n      (irq_n)
	);

	// ----------------------------------------------------------------------
	// read mux, ack cycle takes the vector
	always_comb begin
		if (bus.ack) begin
			rdata = vector;
		end else if (hit_joyp) begin
			rdata = joy_rdata;
		end else if (hit_sb) begin
			rdata = OPEN_BUS; // no link partner, line idles high
		end else if (hit_sc) begin
			rdata = sc_rdata;
		end else if (hit_if) begin
			rdata = if_rdata;
		end else if (hit_ie) begin
			rdata = ie_rdata;
		end else begin
			rdata = OPEN_BUS;
		end
	end

endmodule

`default_nettype wire

/* irq_ctrl.sv */
/*
 * interrupt controller
 *   IF and IE registers, vblank and joypad edge detection
 *   fixed priority encoder, restart vector, ack clearing, irq_n
 */
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl (
	input  wire                        clk,
	input  wire                        reset,
	input  wire                        if_wr,
	input  wire                        ie_wr,
	input  wire gb_io_pkg::byte_t      wdata,
	input  wire                        ack,
	input  wire gb_io_pkg::ext_irq_t   ext,
	input  wire gb_io_pkg::joy_lines_t lines,
	input  wire                        serial_irq,
	output gb_io_pkg::byte_t           if_rdata,
	output gb_io_pkg::byte_t           ie_rdata,
	output gb_io_pkg::byte_t           vector,
	output logic                       irq_n
);
	import gb_io_pkg::*;

	logic [2:0] vb_sync; // [0],[1] synchronizer, [2] previous value
	joy_lines_t lines_s1, lines_s2, lines_d;
	logic       ack_d;   // ack seen at the previous edge
	logic       vb_rise;
	logic       joy_fall;
	irq_mask_t  if_r;
	irq_mask_t  ie_r;
	irq_mask_t  pending; // enabled and flagged
	irq_mask_t  set_mask;
	irq_mask_t  clr_mask; // one hot, highest priority pending
	irq_mask_t  if_next;

	// ----------------------------------------------------------------------
	// event detection
	assign vb_rise  = vb_sync[1] & ~vb_sync[2];
	assign joy_fall = |(~lines_s2 & lines_d); // any P1x line pulled low

	always_comb begin
		set_mask             = '0;
		set_mask[IRQ_VBLANK] = vb_rise;
		set_mask[IRQ_LCD]    = ext.lcd;    // already one cycle wide
		set_mask[IRQ_TIMER]  = ext.timer;
		set_mask[IRQ_SERIAL] = serial_irq;
		set_mask[IRQ_JOYPAD] = joy_fall;
	end

	// ----------------------------------------------------------------------
	// priority encoder
	assign pending = if_r & ie_r;

	always_comb begin
		clr_mask = '0;
		if (pending[IRQ_VBLANK]) begin
			vector               = VEC_VBLANK;
			clr_mask[IRQ_VBLANK] = 1'b1;
		end else if (pending[IRQ_LCD]) begin
			vector            = VEC_LCD;
			clr_mask[IRQ_LCD] = 1'b1;
		end else if (pending[IRQ_TIMER]) begin
			vector              = VEC_TIMER;
			clr_mask[IRQ_TIMER] = 1'b1;
		end else if (pending[IRQ_SERIAL]) begin
			vector               = VEC_SERIAL;
			clr_mask[IRQ_SERIAL] = 1'b1;
		end else if (pending[IRQ_JOYPAD]) begin
			vector               = VEC_JOYPAD;
			clr_mask[IRQ_JOYPAD] = 1'b1;
		end else begin
			vector = VEC_NONE;
		end
	end

	// next flag value: events, then ack clear, then cpu write wins
	always_comb begin
		if_next = if_r | set_mask;
		if (ack_d && !ack) begin // ack cycle just ended
			if_next = if_next & ~clr_mask;
		end
		if (if_wr) begin
			if_next = wdata[IRQ_COUNT-1:0];
		end
	end

	// ----------------------------------------------------------------------
	// registers
	always_ff @(posedge clk) begin
		if (reset) begin
			vb_sync  <= '0;
			lines_s1 <= '1; // lines idle high
			lines_s2 <= '1;
			lines_d  <= '1;
			ack_d    <= 1'b0;
			if_r     <= '0;
			ie_r     <= '0;
		end else begin
			vb_sync  <= {vb_sync[1:0], ext.vblank};
			lines_s1 <= lines;
			lines_s2 <= lines_s1;
			lines_d  <= lines_s2;
			ack_d    <= ack;
			if_r     <= if_next;
			if (ie_wr) begin
				ie_r <= wdata[IRQ_COUNT-1:0];
			end
		end
	end

	assign if_rdata = {{(8 - IRQ_COUNT){1'b1}}, if_r}; // unused bits read high
	assign ie_rdata = {{(8 - IRQ_COUNT){1'b0}}, ie_r};
	assign irq_n    = ~|pending;

	// request line must agree with what the encoder hands out on ack
	a_irq_n_match: assert property (
		@(posedge clk) disable iff (reset)
		irq_n == (vector == VEC_NONE)
	) else $error("irq_n disagrees with the priority vector");

endmodule

`default_nettype wire

/* serial_port.sv */
/*
 * dummy serial port
 *   SC start and shift clock bits
 *   bit time divider and bit counter for internal clock transfers
 *   serial interrupt pulse at the end of a transfer
 */
`timescale 1ns/1ps
`default_nettype none

module serial_port (
	input  wire                   clk,
	input  wire                   reset,
	input  wire                   sel_wr,
	input  wire gb_io_pkg::byte_t wdata,
	output gb_io_pkg::byte_t      rdata,
	output logic                  serial_irq
);
	import gb_io_pkg::*;

	logic                    sc_start;      // SC bit 7, transfer in flight
	logic                    sc_shiftclock; // SC bit 0, 1 = internal clock
	logic [SERIAL_DIV_W-1:0] bit_div;       // clocks left in current bit
	logic [SERIAL_CNT_W-1:0] bit_cnt;       // bits left to shift

	// ----------------------------------------------------------------------
	// transfer engine
	// no partner is attached, so only the timing of a transfer is modelled
	always_ff @(posedge clk) begin
		serial_irq <= 1'b0; // pulse lasts one clock
		if (reset) begin
			sc_start      <= 1'b0;
			sc_shiftclock <= 1'b0;
			bit_div       <= '0;
			bit_cnt       <= '0;
		end else if (sel_wr) begin
			sc_start      <= wdata[7];
			sc_shiftclock <= wdata[0];
			if (wdata[7]) begin // restart from bit 0
				bit_div <= SERIAL_DIV_W'(SERIAL_BIT_CYCLES - 1);
				bit_cnt <= SERIAL_CNT_W'(SERIAL_BITS);
			end
		end else if (sc_start && sc_shiftclock) begin
			if (bit_div == '0) begin
				bit_div <= SERIAL_DIV_W'(SERIAL_BIT_CYCLES - 1); // next bit time
				bit_cnt <= bit_cnt - 1'b1;
				if (bit_cnt == SERIAL_CNT_W'(1)) begin // last bit shifted out
					serial_irq <= 1'b1;
					sc_start   <= 1'b0;
				end
			end else begin
				bit_div <= bit_div - 1'b1;
			end
		end
		// external clock never ticks here, transfer just hangs
	end

	assign rdata = {sc_start, 6'h3f, sc_shiftclock};

	// ----------------------------------------------------------------------
	// checks
	a_bit_cnt_range: assert property (
		@(posedge clk) disable iff (reset)
		bit_cnt <= SERIAL_CNT_W'(SERIAL_BITS)
	) else $error("serial bit counter above %0d", SERIAL_BITS);

	// start clears with the pulse, so no second one follows
	a_irq_single: assert property (
		@(posedge clk) disable iff (reset)
		serial_irq |=> !serial_irq
	) else $error("serial_irq held for two cycles");

endmodule

`default_nettype wire

/* joypad.sv */
/*
 * joypad register
 *   select bits P14/P15, masked active low line groups
 *   read byte composition
 */
`timescale 1ns/1ps
`default_nettype none

module joypad (
	input  wire                    clk,
	input  wire                    reset,
	input  wire                    sel_wr,
	input  wire gb_io_pkg::byte_t  wdata,
	input  wire [7:0]              buttons, // start select B A down up left right
	output gb_io_pkg::byte_t       rdata,
	output gb_io_pkg::joy_lines_t  lines
);
	import gb_io_pkg::*;

	logic [1:0] p54; // [0] deselects directions, [1] deselects buttons

	always_ff @(posedge clk) begin
		if (reset) begin
			p54 <= 2'b00;
		end else if (sel_wr) begin
			p54 <= wdata[5:4];
		end
	end

	// ----------------------------------------------------------------------
	// line groups
	// a pressed key pulls its line low, a deselected group floats high
	assign lines.dirs = ~buttons[3:0] | {4{p54[0]}};
	assign lines.btns = ~buttons[7:4] | {4{p54[1]}};

	// both groups share the same four input pins
	assign rdata = {2'b11, p54, lines.dirs & lines.btns};

	// select bits read back right after a P1 write
	a_joy_sel_readback: assert property (
		@(posedge clk) disable iff (reset)
		sel_wr |=> rdata[5:4] == $past(wdata[5:4])
	) else $error("joypad select bits not loaded by a P1 write");

endmodule

`default_nettype wire

/* gb_io_pkg.sv */
/*
 * shared definitions for the console io block
 *   cpu address and data types, register addresses
 *   interrupt bit positions and restart vectors
 *   serial timing constants, bus and event structs
 */
`default_nettype none

package gb_io_pkg;

	// ----------------------------------------------------------------------
	// address and data
	typedef logic [15:0] addr_t;
	typedef logic [7:0]  byte_t;

	localparam addr_t ADDR_JOYP = 16'hff00; // P1 joypad
	localparam addr_t ADDR_SB   = 16'hff01; // serial data
	localparam addr_t ADDR_SC   = 16'hff02; // serial control
	localparam addr_t ADDR_IF   = 16'hff0f; // interrupt flags
	localparam addr_t ADDR_IE   = 16'hffff; // interrupt enable

	localparam byte_t OPEN_BUS = 8'hff; // nothing drives the data lines

	// ----------------------------------------------------------------------
	// interrupts, bit 0 has the highest priority
	localparam int IRQ_COUNT  = 5;
	localparam int IRQ_VBLANK = 0;
	localparam int IRQ_LCD    = 1;
	localparam int IRQ_TIMER  = 2;
	localparam int IRQ_SERIAL = 3;
	localparam int IRQ_JOYPAD = 4;

	typedef logic [IRQ_COUNT-1:0] irq_mask_t;

	localparam byte_t VEC_VBLANK = 8'h40;
	localparam byte_t VEC_LCD    = 8'h48;
	localparam byte_t VEC_TIMER  = 8'h50;
	localparam byte_t VEC_SERIAL = 8'h58;
	localparam byte_t VEC_JOYPAD = 8'h60;
	localparam byte_t VEC_NONE   = 8'h55; // ack with nothing pending

	// ----------------------------------------------------------------------
	// serial port timing
	localparam int SERIAL_BIT_CYCLES = 512; // 8192 Hz at 4 MHz
	localparam int SERIAL_BITS       = 8;
	localparam int SERIAL_DIV_W      = $clog2(SERIAL_BIT_CYCLES);
	localparam int SERIAL_CNT_W      = $clog2(SERIAL_BITS + 1);

	// ----------------------------------------------------------------------
	// structs
	typedef struct packed {
		addr_t addr;
		byte_t wdata;
		logic  wr;  // one cycle write strobe
		logic  ack; // interrupt acknowledge level
	} cpu_bus_t;

	typedef struct packed {
		logic joyp;
		logic sc;
		logic if_reg;
		logic ie;
	} io_sel_t; // write strobes, SB writes are dropped

	typedef struct packed {
		logic vblank; // level
		logic lcd;    // one cycle pulse
		logic timer;  // one cycle pulse
	} ext_irq_t;

	typedef struct packed {
		logic [3:0] dirs; // P10..P13 with P14 low, active low
		logic [3:0] btns; // P10..P13 with P15 low, active low
	} joy_lines_t;

endpackage

`default_nettype wire
